// ==== hdl/core_mem_pkg.sv ====
/*
 * Core memory slice definitions
 * Bus widths, SPM geometry, reset PC, access size codes and the
 * request and data word types shared by the stages
 */
`default_nettype none

package core_mem_pkg;

    ////////////////////////////////////////////////////////////////////
    // Widths and geometry
    ////////////////////////////////////////////////////////////////////
    localparam int WORD_ADDR_W = 30;            // Word address
    localparam int WORD_DATA_W = 32;            // Data word
    localparam int BYTE_OFS_W  = 2;             // Byte offset inside a word
    localparam int BYTE_W      = 8;
    localparam int HALF_W      = 16;
    localparam int SPM_ADDR_W  = 10;            // Low word address bits into SPM
    localparam int SPM_DEPTH   = 1 << SPM_ADDR_W;

    // First fetch after reset, word address
    localparam logic [WORD_ADDR_W-1:0] RESET_PC = '0;

    // Access size of a memory stage request
    typedef enum logic [1:0] {
        size_byte = 2'b00,
        size_half = 2'b01,
        size_word = 2'b10
    } mem_size_e;

    ////////////////////////////////////////////////////////////////////
    // Memory stage request
    ////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic                              write;     // Store when set
        mem_size_e                         size;
        logic                              zero_ext;  // Loads only
        logic [WORD_ADDR_W+BYTE_OFS_W-1:0] byte_addr;
        logic [WORD_DATA_W-1:0]            wr_data;   // Right aligned
    } mem_req_t;

    // SPM word, whole or per lane; lane n is byte offset n
    typedef union packed {
        logic [WORD_DATA_W-1:0]                         word;
        logic [WORD_DATA_W/BYTE_W-1:0][BYTE_W-1:0]      bytes;
        logic [WORD_DATA_W/HALF_W-1:0][HALF_W-1:0]      halves;
    } spm_word_u;

endpackage

`default_nettype wire

// ==== hdl/bus_if.sv ====
/*
 * Bus interface
 * Lets one pipeline access onto an SPM port unless stalled or flushed,
 * read data is zero for any access that did not go through
 */
`default_nettype none
`timescale 1ns/100ps

module bus_if
    import core_mem_pkg::*;
(
    // Pipeline control
    input  wire logic                   stall,
    input  wire logic                   flush,
    // Stage side
    input  wire logic [WORD_ADDR_W-1:0] addr,
    input  wire logic                   as_n,        // Address strobe, active low
    input  wire logic                   rw,          // Set for write
    input  wire logic [WORD_DATA_W-1:0] wr_data,
    output logic      [WORD_DATA_W-1:0] rd_data,
    // SPM side
    input  wire logic [WORD_DATA_W-1:0] spm_rd_data,
    output logic      [WORD_ADDR_W-1:0] spm_addr,
    output logic                        spm_as_n,
    output logic                        spm_rw,
    output logic      [WORD_DATA_W-1:0] spm_wr_data
);

    logic go;   // Access reaches the SPM this cycle

    // Address, direction and data pass straight through
    assign spm_addr    = addr;
    assign spm_rw      = rw;
    assign spm_wr_data = wr_data;

    assign go = !as_n && !stall && !flush;

    always_comb begin
        if (go) begin
            spm_as_n = 1'b0;
            rd_data  = spm_rd_data;   // Also feeds the sub-word store merge
        end else begin
            spm_as_n = 1'b1;
            rd_data  = '0;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/spm.sv ====
/*
 * Scratchpad memory
 * Two ports, combinational read and write at the rising edge
 */
`default_nettype none
`timescale 1ns/100ps

module spm
    import core_mem_pkg::*;
(
    input  wire logic                   clk,
    // Port a, fetch
    input  wire logic                   a_as_n,
    input  wire logic                   a_rw,
    input  wire logic [WORD_ADDR_W-1:0] a_addr,
    input  wire logic [WORD_DATA_W-1:0] a_wr_data,
    output logic      [WORD_DATA_W-1:0] a_rd_data,
    // Port b, memory stage
    input  wire logic                   b_as_n,
    input  wire logic                   b_rw,
    input  wire logic [WORD_ADDR_W-1:0] b_addr,
    input  wire logic [WORD_DATA_W-1:0] b_wr_data,
    output logic      [WORD_DATA_W-1:0] b_rd_data
);

    logic [WORD_DATA_W-1:0] mem [SPM_DEPTH];

    logic [SPM_ADDR_W-1:0]  a_idx;   // Upper word address bits alias
    logic [SPM_ADDR_W-1:0]  b_idx;
    logic                   a_we;
    logic                   b_we;

    assign a_idx = a_addr[SPM_ADDR_W-1:0];
    assign b_idx = b_addr[SPM_ADDR_W-1:0];

    assign a_we = !a_as_n && a_rw;
    assign b_we = !b_as_n && b_rw;

    ////////////////////////////////////////////////////////////////////
    // Read, no latency
    ////////////////////////////////////////////////////////////////////
    assign a_rd_data = mem[a_idx];
    assign b_rd_data = mem[b_idx];

    ////////////////////////////////////////////////////////////////////
    // Write
    ////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (a_we) begin
            mem[a_idx] <= a_wr_data;
        end
        // Port b after a, never the same word in practice
        if (b_we) begin
            mem[b_idx] <= b_wr_data;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/if_stage.sv ====
/*
 * Fetch stage
 * Word PC with hold on stall and redirect on flush, and the
 * registered instruction with its PC
 */
`default_nettype none
`timescale 1ns/100ps

module if_stage
    import core_mem_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   arst_n,
    // Pipeline control
    input  wire logic                   stall,
    input  wire logic                   flush,
    input  wire logic [WORD_ADDR_W-1:0] br_target,   // Redirect address
    // Bus interface side
    output logic      [WORD_ADDR_W-1:0] addr,
    output logic                        as_n,
    input  wire logic [WORD_DATA_W-1:0] rd_data,
    input  wire logic                   granted,     // Fetch reached the SPM
    // Fetch result
    output logic                        insn_valid,
    output logic      [WORD_DATA_W-1:0] insn,
    output logic      [WORD_ADDR_W-1:0] insn_pc
);

    logic [WORD_ADDR_W-1:0] pc;
    logic [WORD_ADDR_W-1:0] pc_next;

    // Fetch is requested every cycle
    assign addr = pc;
    assign as_n = 1'b0;

    ////////////////////////////////////////////////////////////////////
    // Program counter
    ////////////////////////////////////////////////////////////////////
    always_comb begin
        if (flush) begin
            pc_next = br_target;           // Redirect wins over stall
        end else if (stall) begin
            pc_next = pc;                  // Hold
        end else begin
            pc_next = pc + 1'b1;           // Next word
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc         <= RESET_PC;
            insn_valid <= 1'b0;
        end else begin
            pc         <= pc_next;
            insn_valid <= granted;         // Gating already done in bus_if
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Instruction register
    ////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (granted) begin
            insn    <= rd_data;
            insn_pc <= pc;                 // PC of the word just read
        end
    end

endmodule

`default_nettype wire

// ==== hdl/mem_stage.sv ====
/*
 * Memory stage
 * Word access from a request, sub-word store merge on the word read in
 * the same cycle, load lane select with extension and result register
 */
`default_nettype none
`timescale 1ns/100ps

module mem_stage
    import core_mem_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   arst_n,
    // Request
    input  wire logic                   req,
    input  wire mem_req_t               op,
    // Bus interface side
    output logic      [WORD_ADDR_W-1:0] addr,
    output logic                        as_n,
    output logic                        rw,
    output logic      [WORD_DATA_W-1:0] wr_data,
    input  wire logic [WORD_DATA_W-1:0] rd_data,
    input  wire logic                   granted,    // From the SPM port strobe
    // Load result
    output logic                        load_valid,
    output logic      [WORD_DATA_W-1:0] load_data
);

    spm_word_u              rd_word;   // Word read this cycle
    spm_word_u              merged;    // Store data after merge
    logic [BYTE_OFS_W-1:0]  ofs;       // Byte offset inside the word
    logic [BYTE_W-1:0]      lane_byte;
    logic [HALF_W-1:0]      lane_half;
    logic [WORD_DATA_W-1:0] load_ext;  // Extended load value
    logic                   load_take;

    assign addr    = op.byte_addr[WORD_ADDR_W+BYTE_OFS_W-1:BYTE_OFS_W];
    assign as_n    = !req;
    assign rw      = op.write;
    assign ofs     = op.byte_addr[BYTE_OFS_W-1:0];
    assign rd_word = rd_data;

    ////////////////////////////////////////////////////////////////////
    // Store merge
    ////////////////////////////////////////////////////////////////////
    always_comb begin
        merged = rd_word;
        case (op.size)
            size_byte: merged.bytes[ofs] = op.wr_data[BYTE_W-1:0];
            size_half: merged.halves[ofs[1]] = op.wr_data[HALF_W-1:0];  // Bit 0 ignored
            default: begin
                merged.word = op.wr_data;   // Whole word replaced
            end
        endcase
    end

    assign wr_data = merged.word;

    ////////////////////////////////////////////////////////////////////
    // Load select and extension
    ////////////////////////////////////////////////////////////////////
    assign lane_byte = rd_word.bytes[ofs];
    assign lane_half = rd_word.halves[ofs[1]];

    always_comb begin
        case (op.size)
            size_byte: begin
                if (op.zero_ext) begin
                    load_ext = {{(WORD_DATA_W-BYTE_W){1'b0}}, lane_byte};
                end else begin
                    load_ext = {{(WORD_DATA_W-BYTE_W){lane_byte[BYTE_W-1]}}, lane_byte};
                end
            end
            size_half: begin
                if (op.zero_ext) begin
                    load_ext = {{(WORD_DATA_W-HALF_W){1'b0}}, lane_half};
                end else begin
                    load_ext = {{(WORD_DATA_W-HALF_W){lane_half[HALF_W-1]}}, lane_half};
                end
            end
            default: load_ext = rd_word.word;   // Word load
        endcase
    end

    // Only loads that reached the SPM produce a result
    assign load_take = req && granted && !op.write;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            load_valid <= 1'b0;
        end else begin
            load_valid <= load_take;
        end
    end

    always_ff @(posedge clk) begin
        if (load_take) begin
            load_data <= load_ext;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/core_mem_top.sv ====
/*
 * Core memory slice top
 * Fetch and memory stages, each behind a bus interface, sharing the
 * two-port scratchpad
 */
`default_nettype none
`timescale 1ns/100ps

module core_mem_top
    import core_mem_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   arst_n,
    // Pipeline control
    input  wire logic                   stall,        // Both stages
    input  wire logic                   if_flush,
    input  wire logic [WORD_ADDR_W-1:0] br_target,
    input  wire logic                   mem_flush,
    // Memory request
    input  wire logic                   mem_req,
    input  wire mem_req_t               mem_op,
    // Fetch result
    output logic                        insn_valid,
    output logic      [WORD_DATA_W-1:0] insn,
    output logic      [WORD_ADDR_W-1:0] insn_pc,
    // Load result
    output logic                        load_valid,
    output logic      [WORD_DATA_W-1:0] load_data
);

    ////////////////////////////////////////////////////////////////////
    // Fetch path wires
    ////////////////////////////////////////////////////////////////////
    logic [WORD_ADDR_W-1:0] if_addr;
    logic                   if_as_n;
    logic [WORD_DATA_W-1:0] if_rd_data;
    logic [WORD_ADDR_W-1:0] if_spm_addr;
    logic                   if_spm_as_n;
    logic                   if_spm_rw;
    logic [WORD_DATA_W-1:0] if_spm_wr_data;
    logic [WORD_DATA_W-1:0] if_spm_rd_data;
    logic                   if_granted;

    // Memory path wires
    logic [WORD_ADDR_W-1:0] mem_addr;
    logic                   mem_as_n;
    logic                   mem_rw;
    logic [WORD_DATA_W-1:0] mem_wr_data;
    logic [WORD_DATA_W-1:0] mem_rd_data;
    logic [WORD_ADDR_W-1:0] mem_spm_addr;
    logic                   mem_spm_as_n;
    logic                   mem_spm_rw;
    logic [WORD_DATA_W-1:0] mem_spm_wr_data;
    logic [WORD_DATA_W-1:0] mem_spm_rd_data;
    logic                   mem_granted;

    // Grant is the gated SPM strobe
    assign if_granted  = !if_spm_as_n;
    assign mem_granted = !mem_spm_as_n;

    ////////////////////////////////////////////////////////////////////
    // Stages
    ////////////////////////////////////////////////////////////////////
    if_stage u_if_stage (
        .clk, .arst_n, .stall, .flush(if_flush), .br_target,
        .addr(if_addr), .as_n(if_as_n), .rd_data(if_rd_data), .granted(if_granted),
        .insn_valid, .insn, .insn_pc
    );

    mem_stage u_mem_stage (
        .clk, .arst_n, .req(mem_req), .op(mem_op),
        .addr(mem_addr), .as_n(mem_as_n), .rw(mem_rw), .wr_data(mem_wr_data),
        .rd_data(mem_rd_data), .granted(mem_granted),
        .load_valid, .load_data
    );

    ////////////////////////////////////////////////////////////////////
    // Bus interfaces
    ////////////////////////////////////////////////////////////////////
    bus_if u_if_bus (
        .stall, .flush(if_flush),
        .addr(if_addr), .as_n(if_as_n),
        .rw(1'b0), .wr_data('0),                  // Fetch only reads
        .rd_data(if_rd_data), .spm_rd_data(if_spm_rd_data),
        .spm_addr(if_spm_addr), .spm_as_n(if_spm_as_n),
        .spm_rw(if_spm_rw), .spm_wr_data(if_spm_wr_data)
    );

    bus_if u_mem_bus (
        .stall, .flush(mem_flush),
        .addr(mem_addr), .as_n(mem_as_n), .rw(mem_rw), .wr_data(mem_wr_data),
        .rd_data(mem_rd_data), .spm_rd_data(mem_spm_rd_data),
        .spm_addr(mem_spm_addr), .spm_as_n(mem_spm_as_n),
        .spm_rw(mem_spm_rw), .spm_wr_data(mem_spm_wr_data)
    );

    // Port a fetch, port b memory stage
    spm u_spm (
        .clk,
        .a_as_n(if_spm_as_n), .a_rw(if_spm_rw), .a_addr(if_spm_addr),
        .a_wr_data(if_spm_wr_data), .a_rd_data(if_spm_rd_data),
        .b_as_n(mem_spm_as_n), .b_rw(mem_spm_rw), .b_addr(mem_spm_addr),
        .b_wr_data(mem_spm_wr_data), .b_rd_data(mem_spm_rd_data)
    );

endmodule

`default_nettype wire

// ==== sim/core_mem_properties.sv ====
/*
 * Core memory slice properties
 * Reset quiet outputs, load result causality and fetch PC sequence
 */
`default_nettype none
`timescale 1ns/100ps

module core_mem_properties
    import core_mem_pkg::*;
(
    input wire logic                   clk,
    input wire logic                   arst_n,
    input wire logic                   if_flush,
    input wire logic [WORD_ADDR_W-1:0] br_target,
    input wire logic                   mem_req,
    input wire logic                   insn_valid,
    input wire logic [WORD_ADDR_W-1:0] insn_pc,
    input wire logic                   load_valid
);

    logic [WORD_ADDR_W-1:0] last_pc;    // PC of the last valid fetch
    logic [WORD_ADDR_W-1:0] redir_pc;   // Target of the last flush
    logic                   redir;      // Flush seen since last valid fetch

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            last_pc  <= RESET_PC - 1'b1;   // So the first fetch is RESET_PC
            redir_pc <= RESET_PC;
            redir    <= 1'b0;
        end else begin
            if (insn_valid) last_pc <= insn_pc;
            if (if_flush) begin
                redir    <= 1'b1;
                redir_pc <= br_target;
            end else if (insn_valid) begin
                redir    <= 1'b0;
            end
        end
    end

    reset_quiet: assert property (@(posedge clk) !arst_n |-> !insn_valid && !load_valid)
        else $error("Result strobe high during reset");

    load_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
        !mem_req |=> !load_valid)
        else $error("Load result without a request");

    pc_sequence: assert property (@(posedge clk) disable iff (!arst_n)
        insn_valid |-> (redir ? insn_pc == redir_pc : insn_pc == last_pc + 1'b1))
        else $error("Fetch PC out of sequence");

endmodule

`default_nettype wire

// ==== sim/tb_core_mem.sv ====
/*
 * Core memory slice testbench
 * Random loads, stores and fetches checked against a byte tracked SPM model
 */
`default_nettype none
`timescale 1ns/100ps

module tb_core_mem
    import core_mem_pkg::*;
;
    logic                   clk;
    logic                   arst_n;
    logic                   stall;
    logic                   if_flush;
    logic [WORD_ADDR_W-1:0] br_target;
    logic                   mem_flush;
    logic                   mem_req;
    mem_req_t               mem_op;
    logic                   insn_valid;
    logic [WORD_DATA_W-1:0] insn;
    logic [WORD_ADDR_W-1:0] insn_pc;
    logic                   load_valid;
    logic [WORD_DATA_W-1:0] load_data;

    logic [31:0] spm_model [SPM_DEPTH];      // Expected SPM contents
    logic [3:0]  byte_written [SPM_DEPTH];   // One bit per byte lane
    logic [31:0] rng_state = 32'd53;

    core_mem_top DUT (
        .clk, .arst_n, .stall, .if_flush, .br_target, .mem_flush, .mem_req, .mem_op,
        .insn_valid, .insn, .insn_pc, .load_valid, .load_data
    );

    bind core_mem_top core_mem_properties u_props (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Random numbers and model helpers
    //////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    // Request to a window word, random high bits and low bits
    function automatic mem_req_t make_op(input logic wr, input mem_size_e sz,
                                         input logic [5:0] widx);
        mem_req_t    op;
        logic [31:0] r;
        r = next_rand();
        op.write     = wr;
        op.size      = sz;
        op.zero_ext  = r[0];
        op.byte_addr = {r[31:12], 4'b0000, widx, r[2:1]};   // High bits alias away
        op.wr_data   = next_rand();
        return op;
    endfunction

    function automatic logic [3:0] lane_mask(input mem_req_t op);
        case (op.size)
            size_byte: return 4'b0001 << op.byte_addr[1:0];
            size_half: return op.byte_addr[1] ? 4'b1100 : 4'b0011;   // Bit 0 ignored
            default:   return 4'b1111;
        endcase
    endfunction

    function automatic logic [31:0] bit_mask(input logic [3:0] lanes);
        return {{8{lanes[3]}}, {8{lanes[2]}}, {8{lanes[1]}}, {8{lanes[0]}}};
    endfunction

    function automatic logic [31:0] merge_store(input logic [31:0] word, input mem_req_t op);
        logic [31:0] m;
        int          sh;
        m  = bit_mask(lane_mask(op));
        sh = (op.size == size_word) ? 0 : 8 * (op.size == size_half ?
             2 * op.byte_addr[1] : op.byte_addr[1:0]);
        return (word & ~m) | ((op.wr_data << sh) & m);
    endfunction

    function automatic logic [31:0] expect_load(input logic [31:0] word, input mem_req_t op);
        logic [31:0] s;
        case (op.size)
            size_byte: begin
                s = word >> (8 * op.byte_addr[1:0]);
                return op.zero_ext ? {24'h0, s[7:0]} : {{24{s[7]}}, s[7:0]};
            end
            size_half: begin
                s = word >> (16 * op.byte_addr[1]);
                return op.zero_ext ? {16'h0, s[15:0]} : {{16{s[15]}}, s[15:0]};
            end
            default:   return word;
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////
    task automatic stop_fail();
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            stop_fail();
        end
    endtask

    // One memory stage cycle; result checked one cycle later
    task automatic run_cycle(input string name, input logic req, input mem_req_t op,
                             input logic stl, input logic flh);
        logic        go;
        logic        exp_valid;
        logic [31:0] exp_data;
        logic [31:0] m;
        logic [9:0]  w;
        w         = op.byte_addr[11:2];
        go        = req && !stl && !flh;                 // Bus interface rule
        exp_valid = go && !op.write;
        exp_data  = expect_load(spm_model[w], op);
        m         = (op.size == size_word) ? bit_mask(byte_written[w]) : '1;
        mem_req   = req;
        mem_op    = op;
        stall     = stl;
        mem_flush = flh;
        @(posedge clk);
        #5;
        if (go && op.write) begin
            spm_model[w]    = merge_store(spm_model[w], op);
            byte_written[w] = byte_written[w] | lane_mask(op);
        end
        check_value({name, "_valid"}, exp_valid, load_valid);
        if (exp_valid) check_value(name, exp_data & m, load_data & m);
    endtask

    // Flush to a target, then follow the fetch stream through random stalls
    task automatic fetch_run(input logic [WORD_ADDR_W-1:0] target, input int count);
        logic [WORD_ADDR_W-1:0] exp_pc;
        logic [31:0]            m;
        logic                   stl;
        int                     got;
        int                     guard;
        mem_req   = 1'b0;
        stall     = 1'b0;
        if_flush  = 1'b1;
        br_target = target;
        @(posedge clk);
        #5;
        if_flush = 1'b0;
        check_value("fetch_flush_valid", 0, insn_valid);
        exp_pc = target;
        got    = 0;
        guard  = 0;
        while (got < count) begin
            stl   = (next_rand() % 4) == 0;
            stall = stl;
            @(posedge clk);
            #5;
            check_value("fetch_valid", !stl, insn_valid);
            if (insn_valid) begin
                m = bit_mask(byte_written[exp_pc[9:0]]);
                check_value("fetch_pc", exp_pc, insn_pc);
                check_value("fetch_insn", spm_model[exp_pc[9:0]] & m, insn & m);
                exp_pc = exp_pc + 1'b1;
                got++;
            end
            guard++;
            assert (guard < 10 * count) else begin
                $display("Timeout waiting for fetched instructions");
                stop_fail();
            end
        end
        stall = 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        mem_req_t   op;
        mem_size_e  sz;
        logic [31:0] r;
        arst_n    = 1'b1;
        stall     = 1'b0;
        if_flush  = 1'b0;
        br_target = '0;
        mem_flush = 1'b0;
        mem_req   = 1'b0;
        mem_op    = '0;
        for (int i = 0; i < SPM_DEPTH; i++) begin
            spm_model[i]    = '0;
            byte_written[i] = '0;
        end
        #1 arst_n = 1'b0;
        repeat (3) @(posedge clk);
        #5 arst_n = 1'b1;

        // 1: fill the window, random word stores, word loads
        for (int i = 0; i < 64; i++) run_cycle("word_fill", 1, make_op(1, size_word, i), 0, 0);
        for (int i = 0; i < 64; i++) run_cycle("word_store", 1, make_op(1, size_word, next_rand()), 0, 0);
        for (int i = 0; i < 64; i++) run_cycle("word_load", 1, make_op(0, size_word, next_rand()), 0, 0);

        // 2: sub-word stores, then every window word read back
        for (int i = 0; i < 64; i++) begin
            r  = next_rand();
            sz = r[0] ? size_half : size_byte;
            run_cycle("sub_store", 1, make_op(1, sz, r[13:8]), 0, 0);
        end
        for (int i = 0; i < 64; i++) run_cycle("sub_check", 1, make_op(0, size_word, i), 0, 0);

        // 3: extended byte and halfword loads
        for (int i = 0; i < 64; i++) begin
            r  = next_rand();
            sz = r[0] ? size_half : size_byte;
            run_cycle("ext_load", 1, make_op(0, sz, r[13:8]), 0, 0);
        end

        // 4: stall and flush drop accesses
        for (int i = 0; i < 96; i++) begin
            r  = next_rand();
            op = make_op(r[0], mem_size_e'(r[7:4] % 3), r[13:8]);
            run_cycle("drop_mix", r[16], op, (r[21:20] == 0), (r[25:24] == 0));
        end
        for (int i = 0; i < 64; i++) run_cycle("drop_check", 1, make_op(0, size_word, i), 0, 0);
        run_cycle("idle", 0, '0, 0, 0);

        // 5: fetch redirects inside the window
        for (int i = 0; i < 4; i++) fetch_run(next_rand() % 48, 16);

        // 6: back to back loads
        for (int i = 0; i < 32; i++) begin
            r = next_rand();
            run_cycle("b2b_load", 1, make_op(0, mem_size_e'(r % 3), r[13:8]), 0, 0);
        end
        run_cycle("idle", 0, '0, 0, 0);

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
hdl/core_mem_pkg.sv
hdl/bus_if.sv
hdl/spm.sv
hdl/if_stage.sv
hdl/mem_stage.sv
hdl/core_mem_top.sv
sim/core_mem_properties.sv
sim/tb_core_mem.sv
